//--- Makefile
TOP := tb_hilo_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps \
		-f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal --timescale 1ns/10ps -j 0 \
		-f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+testbench
hw/hilo_pkg.sv
hw/mul_pipe.sv
hw/div_iter.sv
hw/hilo_regs.sv
hw/mfhl_read.sv
hw/hilo_unit_top.sv
testbench/tb_hilo_unit.sv

//--- hw/div_iter.sv
`timescale 1ns/10ps

module div_iter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 op_valid,
    input  hilo_pkg::hilo_op_t   op,
    input  hilo_pkg::word_t      rs_value,
    input  hilo_pkg::word_t      rt_value,
    output logic                 div_busy,
    output logic                 div_done,
    output hilo_pkg::hilo_word_t div_value
);

    import hilo_pkg::*;

    logic                  start;
    logic                  div_signed;
    word_t                 rs_mag;
    word_t                 rt_mag;
    logic                  busy_q;
    logic [div_cnt_w-1:0]  cnt_q;
    word_t                 rem_q;            // Partial remainder
    word_t                 quo_q;            // Dividend bits out, quotient bits in
    word_t                 dvs_q;            // Divisor magnitude
    logic                  quo_neg_q;
    logic                  rem_neg_q;
    logic [word_w:0]       shifted;
    logic [word_w:0]       trial;
    logic                  fits;
    word_t                 rem_n;
    word_t                 quo_n;

    assign start      = op_valid && !busy_q && ((op == op_div) || (op == op_divu));
    assign div_signed = (op == op_div);

    // Magnitudes of the operands for signed divides
    assign rs_mag = (div_signed && rs_value[word_w-1]) ? -rs_value : rs_value;
    assign rt_mag = (div_signed && rt_value[word_w-1]) ? -rt_value : rt_value;

    // One restoring step
    assign shifted = {rem_q, quo_q[word_w-1]};
    assign trial   = shifted - {1'b0, dvs_q};
    assign fits    = !trial[word_w];         // No borrow means the divisor fits
    assign rem_n   = fits ? trial[word_w-1:0] : shifted[word_w-1:0];
    assign quo_n   = {quo_q[word_w-2:0], fits};

    // Busy and step counter
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= div_cnt_w'(div_steps);
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == div_cnt_w'(1)) begin
                busy_q <= 1'b0;              // HI/LO take the result at this edge
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            quo_q     <= rs_mag;
            dvs_q     <= rt_mag;
            quo_neg_q <= div_signed && (rs_value[word_w-1] ^ rt_value[word_w-1]);
            rem_neg_q <= div_signed && rs_value[word_w-1];   // Follows the dividend
        end else if (busy_q) begin
            rem_q <= rem_n;
            quo_q <= quo_n;
        end
    end

    // Final step result with the signs corrected
    assign div_value.pair.hi = rem_neg_q ? -rem_n : rem_n;
    assign div_value.pair.lo = quo_neg_q ? -quo_n : quo_n;

    assign div_done = busy_q && (cnt_q == div_cnt_w'(1));
    assign div_busy = busy_q;

endmodule

//--- hw/hilo_pkg.sv
package hilo_pkg;

    // Data path widths
    localparam int word_w = 32;
    localparam int hilo_w = 2 * word_w;   // HI and LO side by side

    // Restoring divider runs one quotient bit per cycle
    localparam int div_steps = 32;
    localparam int div_cnt_w = $clog2(div_steps + 1);

    typedef logic [word_w-1:0] word_t;

    // Decoded HI/LO command, one per strobe
    typedef enum logic [2:0] {
        op_mult  = 3'd0,   // Signed 64-bit product
        op_multu = 3'd1,   // Unsigned 64-bit product
        op_div   = 3'd2,   // Signed quotient/remainder
        op_divu  = 3'd3,   // Unsigned quotient/remainder
        op_mthi  = 3'd4,   // rs to HI
        op_mtlo  = 3'd5,   // rs to LO
        op_mfhi  = 3'd6,   // HI to rd
        op_mflo  = 3'd7    // LO to rd
    } hilo_op_t;

    // HI sits in the upper half, as in the product
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_pair_t;

    // Same 64 bits seen as a register pair or as one product
    typedef union packed {
        hilo_pair_t          pair;
        logic [hilo_w-1:0]   prod;
    } hilo_word_t;

endpackage

//--- hw/hilo_regs.sv
`timescale 1ns/10ps

module hilo_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pipe_hi_we,
    input  logic                 pipe_lo_we,
    input  hilo_pkg::hilo_word_t pipe_value,
    input  logic                 div_done,
    input  hilo_pkg::hilo_word_t div_value,
    output hilo_pkg::word_t      hi,
    output hilo_pkg::word_t      lo
);

    import hilo_pkg::*;

    word_t hi_q;
    word_t lo_q;

    // HI: multiply/move first, divider second
    always_ff @(posedge clk) begin
        if (rst) begin
            hi_q <= '0;
        end else if (pipe_hi_we) begin
            hi_q <= pipe_value.pair.hi;
        end else if (div_done) begin
            hi_q <= div_value.pair.hi;         // Remainder
        end
    end

    // LO with the same priority
    always_ff @(posedge clk) begin
        if (rst) begin
            lo_q <= '0;
        end else if (pipe_lo_we) begin
            lo_q <= pipe_value.pair.lo;
        end else if (div_done) begin
            lo_q <= div_value.pair.lo;         // Quotient
        end
    end

    assign hi = hi_q;
    assign lo = lo_q;

endmodule

//--- hw/hilo_unit_top.sv
`timescale 1ns/10ps

module hilo_unit_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               op_valid,
    input  hilo_pkg::hilo_op_t op,
    input  hilo_pkg::word_t    rs_value,
    input  hilo_pkg::word_t    rt_value,
    output logic               div_busy,
    output logic               rd_valid,
    output hilo_pkg::word_t    rd_data
);

    import hilo_pkg::*;

    logic       pipe_hi_we;
    logic       pipe_lo_we;
    hilo_word_t pipe_value;
    logic       div_done;
    hilo_word_t div_value;
    word_t      hi;
    word_t      lo;

    mul_pipe u_mul_pipe (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .div_busy   (div_busy),
        .pipe_hi_we (pipe_hi_we),
        .pipe_lo_we (pipe_lo_we),
        .pipe_value (pipe_value)
    );

    div_iter u_div_iter (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .div_busy   (div_busy),
        .div_done   (div_done),
        .div_value  (div_value)
    );

    hilo_regs u_hilo_regs (
        .clk        (clk),
        .rst        (rst),
        .pipe_hi_we (pipe_hi_we),
        .pipe_lo_we (pipe_lo_we),
        .pipe_value (pipe_value),
        .div_done   (div_done),
        .div_value  (div_value),
        .hi         (hi),
        .lo         (lo)
    );

    mfhl_read u_mfhl_read (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .div_busy   (div_busy),
        .pipe_hi_we (pipe_hi_we),
        .pipe_lo_we (pipe_lo_we),
        .pipe_value (pipe_value),
        .hi         (hi),
        .lo         (lo),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

endmodule

//--- hw/mfhl_read.sv
`timescale 1ns/10ps

module mfhl_read (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 op_valid,
    input  hilo_pkg::hilo_op_t   op,
    input  logic                 div_busy,
    input  logic                 pipe_hi_we,
    input  logic                 pipe_lo_we,
    input  hilo_pkg::hilo_word_t pipe_value,
    input  hilo_pkg::word_t      hi,
    input  hilo_pkg::word_t      lo,
    output logic                 rd_valid,
    output hilo_pkg::word_t      rd_data
);

    import hilo_pkg::*;

    logic  read_req;
    word_t hi_fwd;
    word_t lo_fwd;
    word_t rd_sel;

    assign read_req = op_valid && !div_busy && ((op == op_mfhi) || (op == op_mflo));

    // A write landing at this edge is newer than the register
    assign hi_fwd = pipe_hi_we ? pipe_value.pair.hi : hi;
    assign lo_fwd = pipe_lo_we ? pipe_value.pair.lo : lo;
    assign rd_sel = (op == op_mfhi) ? hi_fwd : lo_fwd;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_req;              // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (read_req) begin
            rd_data <= rd_sel;
        end
    end

endmodule

//--- hw/mul_pipe.sv
`timescale 1ns/10ps

module mul_pipe (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 op_valid,
    input  hilo_pkg::hilo_op_t   op,
    input  hilo_pkg::word_t      rs_value,
    input  hilo_pkg::word_t      rt_value,
    input  logic                 div_busy,
    output logic                 pipe_hi_we,
    output logic                 pipe_lo_we,
    output hilo_pkg::hilo_word_t pipe_value
);

    import hilo_pkg::*;

    logic                  accept;
    logic                  is_mul;
    logic                  mul_signed;
    logic                  s1_is_mul;
    logic                  s1_we_hi;
    logic                  s1_we_lo;
    logic signed [word_w:0] s1_a;          // Operands with one extension bit
    logic signed [word_w:0] s1_b;
    word_t                 s1_move;
    logic signed [hilo_w-1:0] prod_full;

    assign accept     = op_valid && !div_busy;   // Refused while dividing
    assign is_mul     = (op == op_mult) || (op == op_multu);
    assign mul_signed = (op == op_mult);

    // Stage 1 control
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_is_mul <= 1'b0;
            s1_we_hi  <= 1'b0;
            s1_we_lo  <= 1'b0;
        end else begin
            s1_is_mul <= accept && is_mul;
            s1_we_hi  <= accept && (is_mul || (op == op_mthi));
            s1_we_lo  <= accept && (is_mul || (op == op_mtlo));
        end
    end

    // Stage 1 operands
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_a    <= {mul_signed & rs_value[word_w-1], rs_value};   // Sign or zero extend
            s1_b    <= {mul_signed & rt_value[word_w-1], rt_value};
            s1_move <= rs_value;
        end
    end

    // Stage 2 forms the write that lands at the next edge
    assign prod_full = s1_a * s1_b;

    always_comb begin
        if (s1_is_mul) begin
            pipe_value.prod = prod_full;
        end else begin
            // The write enable picks which half actually takes the move
            pipe_value.pair.hi = s1_move;
            pipe_value.pair.lo = s1_move;
        end
    end

    assign pipe_hi_we = s1_we_hi;
    assign pipe_lo_we = s1_we_lo;

endmodule

//--- testbench/tb_hilo_cases.svh
`ifndef TB_HILO_CASES_SVH
`define TB_HILO_CASES_SVH

// Columns: opcode, rs, rt, wait for idle afterwards, random operands
task automatic load_cases();
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);   // Reset state
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mult,  32'hFFFF_FFF9, 32'h0000_0005, 1'b1, 1'b0);   // -7 * 5
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_multu, 32'hFFFF_FFF9, 32'h0000_0005, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mult,  32'h8000_0000, 32'h7FFF_FFFF, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    // Back to back, reads take the write landing at the same edge
    add_case(op_mult,  32'h1234_5678, 32'h9ABC_DEF0, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mthi,  32'hCAFE_F00D, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mtlo,  32'h0BAD_BEEF, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);   // HI untouched
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    // Four sign combinations, then unsigned
    add_case(op_div,   32'h0000_0064, 32'h0000_0007, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_div,   32'hFFFF_FF9C, 32'h0000_0007, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_div,   32'h0000_0064, 32'hFFFF_FFF9, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_div,   32'hFFFF_FF9C, 32'hFFFF_FFF9, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_divu,  32'hFFFF_FF9C, 32'h0000_0007, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_div,   32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1);   // Random operands
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_divu,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
    // MTHI while the divider runs is dropped
    add_case(op_div,   32'h7FFF_FFFF, 32'h0000_0010, 1'b0, 1'b0);
    add_case(op_mthi,  32'h5555_5555, 32'h0000_0000, 1'b1, 1'b0);
    add_case(op_mfhi,  32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    add_case(op_mflo,  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
endtask

`endif

//--- testbench/tb_hilo_unit.sv
`timescale 1ns/10ps

module tb_hilo_unit;

    import hilo_pkg::*;

    localparam int read_timeout = 3;
    localparam int busy_timeout = 40;

    logic     clk;
    logic     rst;
    logic     op_valid;
    hilo_op_t op;
    word_t    rs_value;
    word_t    rt_value;
    logic     div_busy;
    logic     rd_valid;
    word_t    rd_data;

    // Stimulus table
    hilo_op_t case_op[$];
    word_t    case_rs[$];
    word_t    case_rt[$];
    bit       case_wait[$];
    bit       case_rand[$];

    hilo_word_t model;         // Expected HI/LO
    int         edge_cnt;
    int         busy_until;    // First edge that accepts a command again
    int         seed;
    int         errors;
    int         checks;
    int         row_errors;

    hilo_unit_top uut (
        .clk      (clk),
        .rst      (rst),
        .op_valid (op_valid),
        .op       (op),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .div_busy (div_busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic add_case(input hilo_op_t c_op, input word_t c_rs, input word_t c_rt,
                            input bit c_wait, input bit c_rand);
        case_op.push_back(c_op);
        case_rs.push_back(c_rs);
        case_rt.push_back(c_rt);
        case_wait.push_back(c_wait);
        case_rand.push_back(c_rand);
    endtask

    `include "tb_hilo_cases.svh"

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errors++;
            $display("CHECK FAILED %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            row_errors++;
            $display("CHECK FAILED %s: got %1h, expected %1h", name, got, exp);
        end
    endtask

    // HI/LO after an accepted command by the MIPS rules
    task automatic model_update(input hilo_op_t c_op, input word_t a, input word_t b);
        longint      sa;
        longint      sb;
        logic [63:0] ua;
        logic [63:0] ub;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (c_op)
            op_mult:  model.prod = sa * sb;
            op_multu: model.prod = ua * ub;
            op_div: begin
                model.pair.lo = word_t'(sa / sb);   // Truncates toward zero
                model.pair.hi = word_t'(sa % sb);   // Sign of the dividend
            end
            op_divu: begin
                model.pair.lo = word_t'(ua / ub);
                model.pair.hi = word_t'(ua % ub);
            end
            op_mthi:  model.pair.hi = a;
            op_mtlo:  model.pair.lo = a;
            default: ;
        endcase
    endtask

    // Strobe held for one cycle from 1 ns after an edge
    task automatic issue_cmd(input hilo_op_t c_op, input word_t a, input word_t b,
                             output bit accepted);
        accepted = (edge_cnt + 1 >= busy_until);
        op_valid = 1'b1;
        op       = c_op;
        rs_value = a;
        rt_value = b;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    // Next edge is the last one that still sees the divider busy
    task automatic wait_last_busy_cycle();
        int waited;
        waited = 0;
        while ((edge_cnt + 2 < busy_until) && waited < busy_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic collect_read(input word_t exp);
        int waited;
        waited = 0;
        while (!rd_valid && waited < read_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (rd_valid) begin
            check_word("rd_data", rd_data, exp);
        end else begin
            errors++;
            row_errors++;
            $display("Timeout: rd_valid did not rise within %0d cycles", read_timeout);
        end
    endtask

    task automatic drain_divider();
        int waited;
        waited = 0;
        while (div_busy && waited < busy_timeout) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (div_busy) begin
            errors++;
            row_errors++;
            $display("Timeout: div_busy stayed high for %0d cycles", busy_timeout);
        end
    endtask

    initial begin
        int    i;
        bit    accepted;
        word_t a;
        word_t b;
        clk        = 1'b0;
        rst        = 1'b1;
        op_valid   = 1'b0;
        op         = op_mfhi;
        rs_value   = '0;
        rt_value   = '0;
        edge_cnt   = 0;
        busy_until = 0;
        seed       = 54;
        errors     = 0;
        checks     = 0;
        row_errors = 0;
        model.prod = '0;
        load_cases();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("div_busy", div_busy, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        $display("reset state %s", (row_errors == 0) ? "ok" : "mismatch");
        for (i = 0; i < case_op.size(); i++) begin
            row_errors = 0;
            a = case_rs[i];
            b = case_rt[i];
            if (case_rand[i]) begin
                a = $random(seed);
                b = $random(seed);
                if (b == '0) begin
                    b = 32'd1;                      // Divide by zero is undefined
                end
            end
            if (edge_cnt + 1 < busy_until) begin
                // A wrongly taken write would then land after the divide result
                wait_last_busy_cycle();
                check_flag("div_busy", div_busy, 1'b1);
            end
            issue_cmd(case_op[i], a, b, accepted);
            if (accepted) begin
                model_update(case_op[i], a, b);
                if ((case_op[i] == op_div) || (case_op[i] == op_divu)) begin
                    busy_until = edge_cnt + div_steps + 1;
                    check_flag("div_busy", div_busy, 1'b1);
                end
            end
            if (case_op[i] == op_mfhi) begin
                collect_read(model.pair.hi);
            end else if (case_op[i] == op_mflo) begin
                collect_read(model.pair.lo);
            end
            if (case_wait[i]) begin
                @(posedge clk);
                #1;
                drain_divider();
            end
            $display("case %0d %s rs=%08h rt=%08h %s", i, case_op[i].name(), a, b,
                     (row_errors == 0) ? "ok" : "mismatch");
        end
        $display("%0d cases, %0d checks, %0d errors", case_op.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
